// ==== logic/arm_pkg.sv ====
package arm_pkg;

    // Datapath widths
    localparam int word_w  = 32;
    localparam int cond_w  = 4;     // Condition field, bits 31:28
    localparam int flags_w = 4;     // N Z C V
    localparam int alu_w   = 4;     // ALU opcode, bits 24:21
    localparam int reg_w   = 4;     // Register index, 16 regs
    localparam int class_w = 3;     // Class field, bits 27:25

    typedef logic [word_w-1:0]  word_t;
    typedef logic [cond_w-1:0]  cond_t;
    typedef logic [flags_w-1:0] flags_t;     // N at bit 3, V at bit 0
    typedef logic [alu_w-1:0]   alu_op_t;
    typedef logic [reg_w-1:0]   reg_idx_t;

    // ALU opcodes used by address and branch arithmetic
    localparam alu_op_t alu_add = 4'b0100;
    localparam alu_op_t alu_sub = 4'b0010;

    // Unconditional codes
    localparam cond_t cond_always = 4'b1110;
    localparam cond_t cond_never  = 4'b1111;

    // BL return address goes to r14
    localparam reg_idx_t link_reg = 4'd14;

    // Instruction class, same encoding as bits 27:25
    typedef enum logic [class_w-1:0] {
        class_dp_shift    = 3'b000,     // Data processing, shift by imm
        class_dp_imm      = 3'b001,     // Data processing, immediate
        class_ls_imm      = 3'b010,     // Load/store, immediate offset
        class_ls_reg      = 3'b011,     // Load/store, register offset
        class_branch      = 3'b101,     // B and BL
        class_unsupported = 3'b111      // Anything else
    } instr_class_t;

    // Control word passed from decode into execute
    typedef struct packed {
        logic         valid;        // Slot holds a live instruction
        instr_class_t iclass;
        cond_t        cond;
        alu_op_t      alu_op;
        logic         shift_imm;    // Operand 2 is the immediate
        logic         rf_enable;    // Writes rd
        logic         load;         // Memory read into rd
        logic         mem_write;    // Store
        logic         branch;
        logic         link;         // BL, rd is link_reg
        logic         set_flags;    // S bit
        reg_idx_t     rd;
    } ctrl_t;

endpackage

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ns

module instr_decoder
    import arm_pkg::*;
(
    input  word_t instr,
    input  logic  instr_valid,
    output ctrl_t id_ctrl
);

    instr_class_t iclass;   // Decoded bits 27:25
    logic         bl;       // Branch and link

    // Fold the unused class encodings into one code
    always_comb
    begin
        case (instr[27:25])
            3'b000:  iclass = class_dp_shift;
            3'b001:  iclass = class_dp_imm;
            3'b010:  iclass = class_ls_imm;
            3'b011:  iclass = class_ls_reg;
            3'b101:  iclass = class_branch;
            default: iclass = class_unsupported;   // 100, 110, 111
        endcase
    end

    assign bl = (iclass == class_branch) && instr[24];     // L bit

    always_comb
    begin
        // Start idle and let each class set its own strobes
        id_ctrl        = '0;
        id_ctrl.valid  = instr_valid;
        id_ctrl.iclass = iclass;
        id_ctrl.cond   = instr[31:28];
        id_ctrl.rd     = bl ? link_reg : instr[15:12];     // BL writes r14

        case (iclass)
            class_dp_shift, class_dp_imm:
            begin
                id_ctrl.alu_op    = instr[24:21];      // Opcode straight from the word
                id_ctrl.rf_enable = 1'b1;
                id_ctrl.shift_imm = (iclass == class_dp_imm);
                id_ctrl.set_flags = instr[20];         // S bit
            end

            class_ls_imm, class_ls_reg:
            begin
                // U bit picks offset direction
                id_ctrl.alu_op    = instr[23] ? alu_add : alu_sub;
                id_ctrl.load      = instr[20];         // L bit set for LDR
                id_ctrl.rf_enable = instr[20];         // Only loads write back
                id_ctrl.mem_write = ~instr[20];        // STR
            end

            class_branch:
            begin
                id_ctrl.alu_op    = alu_add;           // PC plus offset
                id_ctrl.branch    = 1'b1;
                id_ctrl.link      = bl;
                id_ctrl.rf_enable = bl;                // Return address into r14
            end

            default:
            begin
                // Unsupported class keeps the idle word
            end
        endcase
    end

endmodule

// ==== logic/id_ex_register.sv ====
`timescale 1ns/1ns

module id_ex_register
    import arm_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  ctrl_t id_ctrl,
    input  logic  branch_taken,     // Squash strobe from execute
    output ctrl_t ex_ctrl
);

    ctrl_t next_ctrl;   // Word loaded at the next edge

    // Taken branch kills the instruction behind it
    always_comb
    begin
        next_ctrl = id_ctrl;
        if (branch_taken)
        begin
            // Only valid drops, other fields still show in waves
            next_ctrl.valid = 1'b0;
        end
    end

    // Stage register, advances every cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ex_ctrl <= '0;      // Empty slot out of reset
        end
        else
        begin
            ex_ctrl <= next_ctrl;
        end
    end

endmodule

// ==== logic/cond_evaluator.sv ====
`timescale 1ns/1ns

module cond_evaluator
    import arm_pkg::*;
(
    input  cond_t  cond,
    input  flags_t flags,
    output logic   passed
);

    logic n;    // Negative
    logic z;    // Zero
    logic c;    // Carry
    logic v;    // Overflow

    assign n = flags[3];
    assign z = flags[2];
    assign c = flags[1];
    assign v = flags[0];

    // Full ARM condition table
    always_comb
    begin
        case (cond)
            4'b0000:     passed = z;                 // EQ
            4'b0001:     passed = ~z;                // NE
            4'b0010:     passed = c;                 // CS/HS
            4'b0011:     passed = ~c;                // CC/LO
            4'b0100:     passed = n;                 // MI
            4'b0101:     passed = ~n;                // PL
            4'b0110:     passed = v;                 // VS
            4'b0111:     passed = ~v;                // VC
            4'b1000:     passed = c & ~z;            // HI unsigned higher
            4'b1001:     passed = ~c | z;            // LS unsigned lower or same
            4'b1010:     passed = (n == v);          // GE
            4'b1011:     passed = (n != v);          // LT
            4'b1100:     passed = ~z & (n == v);     // GT needs both terms
            4'b1101:     passed = z | (n != v);      // LE
            cond_always: passed = 1'b1;
            cond_never:  passed = 1'b0;
        endcase
    end

endmodule

// ==== logic/execute_control.sv ====
`timescale 1ns/1ns

module execute_control
    import arm_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  ctrl_t    ex_ctrl,
    input  flags_t   flags_in,      // ALU flags of the instruction in execute
    output logic     exec_valid,
    output alu_op_t  alu_op,
    output reg_idx_t rd,
    output logic     rf_we,
    output logic     mem_read,
    output logic     mem_write,
    output logic     branch_taken,
    output logic     link,
    output flags_t   flags          // Status register
);

    logic cond_pass;    // Condition field holds under current flags

    cond_evaluator u_cond_evaluator (
        .cond   (ex_ctrl.cond),
        .flags  (flags),
        .passed (cond_pass)
    );

    // Failing condition turns the slot into a no-op
    assign exec_valid = ex_ctrl.valid & cond_pass;

    // Opcode and destination pass through unqualified
    assign alu_op = ex_ctrl.alu_op;
    assign rd     = ex_ctrl.rd;

    // Strobes only fire for an executing instruction
    assign rf_we        = ex_ctrl.rf_enable & exec_valid;
    assign mem_read     = ex_ctrl.load      & exec_valid;
    assign mem_write    = ex_ctrl.mem_write & exec_valid;
    assign branch_taken = ex_ctrl.branch    & exec_valid;   // Also squashes ID/EX
    assign link         = ex_ctrl.link      & exec_valid;

    // Status register, loads at the end of the execute cycle
    // so the next instruction sees the new flags
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            flags <= '0;
        end
        else if (exec_valid && ex_ctrl.set_flags)
        begin
            flags <= flags_in;  // S bit set and condition passed
        end
    end

endmodule

// ==== logic/arm_decode_core.sv ====
`timescale 1ns/1ns

module arm_decode_core
    import arm_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     instr_valid,   // Level, instr is live
    input  word_t    instr,
    input  flags_t   flags_in,      // ALU flags for the executing instruction
    output logic     exec_valid,
    output alu_op_t  alu_op,
    output reg_idx_t rd,
    output logic     rf_we,
    output logic     mem_read,
    output logic     mem_write,
    output logic     branch_taken,
    output logic     link,
    output flags_t   flags
);

    ctrl_t id_ctrl;     // Decode stage word, combinational
    ctrl_t ex_ctrl;     // Execute stage word

    instr_decoder u_instr_decoder (
        .instr       (instr),
        .instr_valid (instr_valid),
        .id_ctrl     (id_ctrl)
    );

    // Squash path closes the loop from execute back to ID/EX
    id_ex_register u_id_ex_register (
        .clk          (clk),
        .rst_n        (rst_n),
        .id_ctrl      (id_ctrl),
        .branch_taken (branch_taken),
        .ex_ctrl      (ex_ctrl)
    );

    execute_control u_execute_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_ctrl      (ex_ctrl),
        .flags_in     (flags_in),
        .exec_valid   (exec_valid),
        .alu_op       (alu_op),
        .rd           (rd),
        .rf_we        (rf_we),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .branch_taken (branch_taken),
        .link         (link),
        .flags        (flags)
    );

endmodule

// ==== include/exec_types.svh ====
`ifndef EXEC_TYPES_SVH
`define EXEC_TYPES_SVH

// One cycle of DUT outputs, same order as the top-level port list
typedef struct packed {
    logic              exec_valid;
    arm_pkg::alu_op_t  alu_op;
    arm_pkg::reg_idx_t rd;
    logic              rf_we;
    logic              mem_read;
    logic              mem_write;
    logic              branch_taken;
    logic              link;
    arm_pkg::flags_t   flags;       // N Z C V
} exec_out_t;

`endif

// ==== tb/exec_checker.sv ====
`timescale 1ns/1ns
`include "exec_types.svh"

module exec_checker
    import arm_pkg::*;
(
    input  logic      clk,
    input  logic      check_en,     // Expected row is live
    input  int        test_id,
    input  exec_out_t expected,
    input  exec_out_t actual,       // DUT outputs
    output int        pass_count,
    output int        fail_count
);

    int wrong;  // Mismatching signals in the current test

    // Reports one signal, returns 1 on a mismatch
    function automatic int check_field(
        input string      name,
        input logic [3:0] exp_v,
        input logic [3:0] act_v
    );
        if (act_v !== exp_v)
        begin
            $display("Error: test %0d %s expected 0x%h got 0x%h", test_id, name, exp_v, act_v);
            return 1;
        end
        return 0;
    endfunction

    initial
    begin
        pass_count = 0;
        fail_count = 0;
        wrong      = 0;
    end

    // Outputs only move on rising edges, so mid-low-phase is a quiet point
    always @(negedge clk)
    begin
        #2;     // Let the falling-edge stimulus settle
        if (check_en)
        begin
            wrong = 0;
            wrong += check_field("exec_valid", expected.exec_valid, actual.exec_valid);
            wrong += check_field("alu_op", expected.alu_op, actual.alu_op);
            wrong += check_field("rd", expected.rd, actual.rd);
            wrong += check_field("rf_we", expected.rf_we, actual.rf_we);
            wrong += check_field("mem_read", expected.mem_read, actual.mem_read);
            wrong += check_field("mem_write", expected.mem_write, actual.mem_write);
            wrong += check_field("branch_taken", expected.branch_taken, actual.branch_taken);
            wrong += check_field("link", expected.link, actual.link);
            wrong += check_field("flags", expected.flags, actual.flags);

            if (wrong == 0)
            begin
                pass_count++;
                $display("Test %0d passed", test_id);
            end
            else
            begin
                fail_count++;
                $display("Test %0d failed, %0d signals wrong", test_id, wrong);
            end
        end
    end

endmodule

// ==== tb/tb_arm_decode_core.sv ====
`timescale 1ns/1ns
`include "exec_types.svh"

module tb_arm_decode_core
    import arm_pkg::*;
();

    localparam int reset_cycles = 8;
    localparam int clk_period   = 20;
    localparam int n_rows       = 46;

    // Condition codes used by the table
    localparam cond_t cond_eq = 4'h0;
    localparam cond_t cond_ne = 4'h1;
    localparam cond_t cond_cs = 4'h2;
    localparam cond_t cond_mi = 4'h4;
    localparam cond_t cond_hi = 4'h8;
    localparam cond_t cond_ls = 4'h9;
    localparam cond_t cond_ge = 4'ha;
    localparam cond_t cond_lt = 4'hb;
    localparam cond_t cond_gt = 4'hc;
    localparam cond_t cond_le = 4'hd;
    localparam cond_t cond_al = cond_always;

    // Inputs for one row, flags_in belongs to that row's own instruction
    typedef struct packed {
        logic   instr_valid;
        word_t  instr;
        flags_t flags_in;
    } stim_t;

    logic      clk;
    logic      rst_n;
    logic      instr_valid;
    word_t     instr;
    flags_t    flags_in;
    logic      exec_valid;
    alu_op_t   alu_op;
    reg_idx_t  rd;
    logic      rf_we;
    logic      mem_read;
    logic      mem_write;
    logic      branch_taken;
    logic      link;
    flags_t    flags;

    exec_out_t dut_out;
    exec_out_t expected;
    logic      check_en;
    int        test_id;
    int        pass_count;
    int        fail_count;

    stim_t     stim_tab [n_rows];
    exec_out_t exp_tab  [n_rows];
    int        row_count;

    arm_decode_core u_arm_decode_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .flags_in     (flags_in),
        .exec_valid   (exec_valid),
        .alu_op       (alu_op),
        .rd           (rd),
        .rf_we        (rf_we),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .branch_taken (branch_taken),
        .link         (link),
        .flags        (flags)
    );

    assign dut_out = {exec_valid, alu_op, rd, rf_we, mem_read, mem_write,
                      branch_taken, link, flags};

    exec_checker u_exec_checker (
        .clk        (clk),
        .check_en   (check_en),
        .test_id    (test_id),
        .expected   (expected),
        .actual     (dut_out),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    always #(clk_period / 2) clk = ~clk;

    // Data processing, rn = r1, shifter field arbitrary
    function automatic word_t dp_word(input cond_t c, input logic imm, input alu_op_t op,
                                      input logic s, input reg_idx_t r);
        return {c, 2'b00, imm, op, s, 4'h1, r, 12'h005};
    endfunction

    // Single load/store, pre-indexed word, no writeback
    function automatic word_t ls_word(input cond_t c, input logic reg_off, input logic u,
                                      input logic l, input reg_idx_t r);
        return {c, 2'b01, reg_off, 1'b1, u, 1'b0, 1'b0, l, 4'h2, r, 12'h008};
    endfunction

    function automatic word_t branch_word(input cond_t c, input logic l);
        return {c, 3'b101, l, 24'h000010};     // Offset field puts 0 in bits 15:12
    endfunction

    // Classes outside the decoder's set
    function automatic word_t other_word(input cond_t c, input logic [2:0] cls,
                                         input reg_idx_t r);
        return {c, cls, 9'h000, r, 12'h000};
    endfunction

    // Strobes packed as {rf_we, mem_read, mem_write, branch_taken, link}
    task automatic add_row(input logic v, input word_t ins, input flags_t fin,
                           input logic ev, input alu_op_t op, input reg_idx_t r,
                           input logic [4:0] strobes, input flags_t fl);
        stim_tab[row_count] = {v, ins, fin};
        exp_tab[row_count]  = {ev, op, r, strobes, fl};
        row_count++;
    endtask

    task automatic build_table();
        row_count = 0;
        // Class decode with flags at zero
        add_row(1, dp_word(cond_al, 0, 4'hd, 0, 4'h3), 4'h0, 1, 4'hd, 4'h3, 5'b10000, 4'h0);
        add_row(1, dp_word(cond_al, 1, 4'h4, 0, 4'h5), 4'h0, 1, 4'h4, 4'h5, 5'b10000, 4'h0);
        add_row(1, ls_word(cond_al, 0, 1, 1, 4'h7), 4'h0, 1, alu_add, 4'h7, 5'b11000, 4'h0);
        add_row(1, ls_word(cond_al, 1, 0, 0, 4'h2), 4'h0, 1, alu_sub, 4'h2, 5'b00100, 4'h0);
        add_row(1, ls_word(cond_al, 1, 0, 1, 4'h9), 4'h0, 1, alu_sub, 4'h9, 5'b11000, 4'h0);
        add_row(1, ls_word(cond_al, 0, 1, 0, 4'h4), 4'h0, 1, alu_add, 4'h4, 5'b00100, 4'h0);
        add_row(1, other_word(cond_al, 3'b100, 4'h6), 4'h0, 1, 4'h0, 4'h6, 5'b00000, 4'h0);
        add_row(1, other_word(cond_al, 3'b110, 4'h8), 4'h0, 1, 4'h0, 4'h8, 5'b00000, 4'h0);
        // S set loads Z and C, S clear ignores flags_in
        add_row(1, dp_word(cond_al, 0, 4'h2, 1, 4'h1), 4'h6, 1, 4'h2, 4'h1, 5'b10000, 4'h0);
        add_row(1, dp_word(cond_al, 0, 4'hd, 0, 4'h2), 4'h9, 1, 4'hd, 4'h2, 5'b10000, 4'h6);
        add_row(1, dp_word(cond_al, 1, 4'hd, 0, 4'h3), 4'hf, 1, 4'hd, 4'h3, 5'b10000, 4'h6);
        // Flags 0110
        add_row(1, dp_word(cond_eq, 0, 4'h4, 0, 4'h0), 4'h0, 1, 4'h4, 4'h0, 5'b10000, 4'h6);
        add_row(1, dp_word(cond_ne, 0, 4'h4, 0, 4'h1), 4'h0, 0, 4'h4, 4'h1, 5'b00000, 4'h6);
        add_row(1, dp_word(cond_cs, 0, 4'h4, 0, 4'h2), 4'h0, 1, 4'h4, 4'h2, 5'b10000, 4'h6);
        add_row(1, dp_word(cond_mi, 0, 4'h4, 0, 4'h4), 4'h0, 0, 4'h4, 4'h4, 5'b00000, 4'h6);
        add_row(1, dp_word(cond_ge, 0, 4'h4, 0, 4'ha), 4'h0, 1, 4'h4, 4'ha, 5'b10000, 4'h6);
        add_row(1, dp_word(cond_lt, 0, 4'h4, 0, 4'hb), 4'h0, 0, 4'h4, 4'hb, 5'b00000, 4'h6);
        add_row(1, dp_word(cond_gt, 0, 4'h4, 0, 4'hc), 4'h0, 0, 4'h4, 4'hc, 5'b00000, 4'h6);
        add_row(1, dp_word(cond_le, 0, 4'h4, 0, 4'hd), 4'h0, 1, 4'h4, 4'hd, 5'b10000, 4'h6);
        add_row(1, dp_word(cond_hi, 0, 4'h4, 0, 4'h8), 4'h0, 0, 4'h4, 4'h8, 5'b00000, 4'h6);
        add_row(1, dp_word(cond_ls, 0, 4'h4, 0, 4'h9), 4'h0, 1, 4'h4, 4'h9, 5'b10000, 4'h6);
        add_row(1, dp_word(cond_al, 0, 4'h2, 1, 4'h0), 4'h2, 1, 4'h2, 4'h0, 5'b10000, 4'h6);
        // Flags 0010, only C
        add_row(1, dp_word(cond_eq, 0, 4'h4, 0, 4'h0), 4'h0, 0, 4'h4, 4'h0, 5'b00000, 4'h2);
        add_row(1, dp_word(cond_ne, 0, 4'h4, 0, 4'h1), 4'h0, 1, 4'h4, 4'h1, 5'b10000, 4'h2);
        add_row(1, dp_word(cond_gt, 0, 4'h4, 0, 4'hc), 4'h0, 1, 4'h4, 4'hc, 5'b10000, 4'h2);
        add_row(1, dp_word(cond_le, 0, 4'h4, 0, 4'hd), 4'h0, 0, 4'h4, 4'hd, 5'b00000, 4'h2);
        add_row(1, dp_word(cond_hi, 0, 4'h4, 0, 4'h8), 4'h0, 1, 4'h4, 4'h8, 5'b10000, 4'h2);
        add_row(1, dp_word(cond_ls, 0, 4'h4, 0, 4'h9), 4'h0, 0, 4'h4, 4'h9, 5'b00000, 4'h2);
        add_row(1, dp_word(cond_al, 0, 4'h2, 1, 4'h0), 4'h8, 1, 4'h2, 4'h0, 5'b10000, 4'h2);
        // Flags 1000, only N
        add_row(1, dp_word(cond_cs, 0, 4'h4, 0, 4'h2), 4'h0, 0, 4'h4, 4'h2, 5'b00000, 4'h8);
        add_row(1, dp_word(cond_mi, 0, 4'h4, 0, 4'h4), 4'h0, 1, 4'h4, 4'h4, 5'b10000, 4'h8);
        add_row(1, dp_word(cond_ge, 0, 4'h4, 0, 4'ha), 4'h0, 0, 4'h4, 4'ha, 5'b00000, 4'h8);
        add_row(1, dp_word(cond_lt, 0, 4'h4, 0, 4'hb), 4'h0, 1, 4'h4, 4'hb, 5'b10000, 4'h8);
        // Failing condition with S set, flags must hold
        add_row(1, dp_word(cond_eq, 0, 4'h4, 1, 4'h0), 4'hf, 0, 4'h4, 4'h0, 5'b00000, 4'h8);
        // Taken B, next slot squashed
        add_row(1, branch_word(cond_al, 0), 4'h0, 1, alu_add, 4'h0, 5'b00010, 4'h8);
        add_row(1, dp_word(cond_al, 0, 4'hd, 0, 4'h5), 4'h0, 0, 4'hd, 4'h5, 5'b00000, 4'h8);
        add_row(1, branch_word(cond_al, 1), 4'h0, 1, alu_add, link_reg, 5'b10011, 4'h8);
        add_row(1, ls_word(cond_al, 0, 1, 1, 4'h7), 4'h0, 0, alu_add, 4'h7, 5'b00000, 4'h8);
        // BEQ fails with Z clear, follower survives
        add_row(1, branch_word(cond_eq, 0), 4'h0, 0, alu_add, 4'h0, 5'b00000, 4'h8);
        add_row(1, dp_word(cond_al, 0, 4'hd, 0, 4'h9), 4'h0, 1, 4'hd, 4'h9, 5'b10000, 4'h8);
        add_row(1, branch_word(cond_mi, 0), 4'h0, 1, alu_add, 4'h0, 5'b00010, 4'h8);
        add_row(1, ls_word(cond_al, 0, 1, 0, 4'h4), 4'h0, 0, alu_add, 4'h4, 5'b00000, 4'h8);
        // instr_valid low
        add_row(0, dp_word(cond_al, 0, 4'hd, 0, 4'h3), 4'h0, 0, 4'hd, 4'h3, 5'b00000, 4'h8);
        add_row(1, dp_word(cond_al, 0, 4'hd, 0, 4'h1), 4'h0, 1, 4'hd, 4'h1, 5'b10000, 4'h8);
        add_row(0, branch_word(cond_al, 0), 4'h0, 0, alu_add, 4'h0, 5'b00000, 4'h8);
        add_row(1, dp_word(cond_al, 0, 4'hd, 0, 4'h2), 4'h0, 1, 4'hd, 4'h2, 5'b10000, 4'h8);
    endtask

    // Watchdog
    initial
    begin
        #((reset_cycles + n_rows * 2) * clk_period);
        $display("Timeout: the stimulus table did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        flags_in    = '0;
        check_en    = 1'b0;
        test_id     = 0;
        expected    = '0;
        build_table();

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n    = 1'b1;
        check_en = 1'b1;    // Test 0, idle outputs straight out of reset

        // Row i goes in while row i-1 executes and is checked
        for (int i = 0; i <= row_count; i++)
        begin
            @(negedge clk);
            if (i > 0)
            begin
                flags_in = stim_tab[i-1].flags_in;     // ALU result of the executing row
                expected = exp_tab[i-1];
                test_id  = i;
                check_en = 1'b1;
            end
            else
            begin
                check_en = 1'b0;
            end

            if (i < row_count)
            begin
                instr_valid = stim_tab[i].instr_valid;
                instr       = stim_tab[i].instr;
            end
            else
            begin
                instr_valid = 1'b0;     // Drain
                instr       = '0;
            end
        end

        @(posedge clk);     // Last compare is done by now
        check_en = 1'b0;
        $display("Totals: %0d passed, %0d failed", pass_count, fail_count);
        if (pass_count + fail_count != row_count + 1)
            $display("Only %0d of %0d tests were checked", pass_count + fail_count,
                     row_count + 1);

        if (fail_count == 0 && pass_count == row_count + 1)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
logic/arm_pkg.sv
logic/instr_decoder.sv
logic/id_ex_register.sv
logic/cond_evaluator.sv
logic/execute_control.sv
logic/arm_decode_core.sv
tb/exec_checker.sv
tb/tb_arm_decode_core.sv
